// File: hdl/neuron_pool_pkg.sv
package neuron_pool_pkg;

    ////////////////////
    // pool geometry
    ////////////////////
    localparam int NUM_NEURON = 16;
    localparam int IDX_W = 4;
    // four phases per neuron slot
    localparam int PHASE_W = 2;
    localparam int POOL_CYCLES = NUM_NEURON << PHASE_W;

    ////////////////////
    // fixed point, 1.0 = 0x10000
    ////////////////////
    localparam int FX_W = 18;
    localparam int FX_FRAC = 16;
    // wide accumulator, holds a full FX x FX product
    localparam int ACC_W = 2 * FX_W;
    localparam logic signed [FX_W-1:0] FX_MAX = 18'sh1_FFFF;
    localparam logic signed [FX_W-1:0] FX_MIN = 18'sh2_0000;

    ////////////////////
    // izhikevich constants, 100 mV units
    ////////////////////
    // a = 1/8
    localparam int A_SHIFT = 3;
    // b = 1/4
    localparam int B_SHIFT = 2;
    // integration step dt = 1/4
    localparam int TAU_SHIFT = 2;
    // -0.65
    localparam logic signed [FX_W-1:0] C_RESET = 18'sh3_599A;
    // 0.08
    localparam logic signed [FX_W-1:0] D_STEP = 18'sh0_147A;
    // spike threshold, +0.30
    localparam logic signed [FX_W-1:0] V_PEAK = 18'sh0_4CCC;
    // constant term 140 mV -> 1.40
    localparam logic signed [FX_W-1:0] K_BIAS = 18'sh1_6666;
    // v*v sits at 2^32, take it to 2^16 and times 4 (0.04 in mV units)
    localparam int VV_SHIFT = FX_FRAC - 2;

    ////////////////////
    // noise source
    ////////////////////
    localparam int NOISE_W = 5;
    localparam int LFSR_W = 32;
    // x^32 + x^22 + x^2 + x + 1, right shifting galois form
    localparam logic [LFSR_W-1:0] LFSR_TAPS = 32'h8020_0003;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 32'h0000_0001;

    ////////////////////
    // spike output
    ////////////////////
    localparam int SPK_ID_W = 16;
    // index field of the id, upper bits padded with zero
    localparam int SPK_IDX_W = 7;
    localparam int SPK_LOW_W = SPK_ID_W - SPK_IDX_W - 2;
    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int CREDIT_INIT = 4;
    localparam int CREDIT_W = $clog2(CREDIT_INIT + 1);

    // one spike from the core
    typedef struct packed {
        logic [IDX_W-1:0] index;
        logic             valid;
    } spike_event_t;

endpackage

// File: hdl/pool_phase_if.sv
`timescale 1ns/1ps

interface pool_phase_if import neuron_pool_pkg::*; ();

    // slot currently owned by the shared core
    logic [IDX_W-1:0] neuron_index;
    // phase 0, index has moved on
    logic advance;
    // phase 1, state read and current load
    logic read_strobe;
    // phase 2, update arithmetic
    logic compute_strobe;
    // phase 3, write back and spike decision
    logic write_strobe;

    modport seq (
        output neuron_index, advance, read_strobe, compute_strobe, write_strobe
    );

    modport user (
        input neuron_index, advance, read_strobe, compute_strobe, write_strobe
    );

endinterface

// File: hdl/pool_sequencer.sv
`timescale 1ns/1ps

module pool_sequencer import neuron_pool_pkg::*; (
    input  logic      i_neuron_clk,
    input  logic      i_reset_sim,
    pool_phase_if.seq phase
);

    // {index, phase} in one counter
    logic [IDX_W+PHASE_W-1:0] pool_count;
    logic [PHASE_W-1:0]       phase_sel;

    ////////////////////
    // neuron counter
    ////////////////////
    always_ff @(posedge i_neuron_clk or posedge i_reset_sim) begin
        if (i_reset_sim) begin
            pool_count <= '0;
        end else if (pool_count == (IDX_W+PHASE_W)'(POOL_CYCLES - 1)) begin
            // last phase of last neuron, back to slot 0
            pool_count <= '0;
        end else begin
            pool_count <= pool_count + 1'b1;
        end
    end

    // low bits select the phase
    assign phase_sel = pool_count[PHASE_W-1:0];
    assign phase.neuron_index = pool_count[IDX_W+PHASE_W-1:PHASE_W];

    ////////////////////
    // one-hot strobes
    ////////////////////
    assign phase.advance = (phase_sel == 2'd0);
    assign phase.read_strobe = (phase_sel == 2'd1);
    assign phase.compute_strobe = (phase_sel == 2'd2);
    assign phase.write_strobe = (phase_sel == 2'd3);

endmodule

// File: hdl/input_current.sv
`timescale 1ns/1ps

module input_current import neuron_pool_pkg::*; (
    input  logic                   i_neuron_clk,
    input  logic                   i_reset_sim,
    input  logic signed [FX_W-1:0] i_rate,
    input  logic signed [FX_W-1:0] i_coef,
    input  logic signed [FX_W-1:0] i_gain,
    input  logic                   i_noise_en,
    pool_phase_if.user             phase,
    output logic signed [FX_W-1:0] o_current
);

    logic [LFSR_W-1:0]        lfsr;
    logic signed [ACC_W-1:0]  rate_prod;
    logic signed [FX_W-1:0]   rate_scaled;
    logic signed [FX_W-1:0]   noise_term;
    logic signed [FX_W-1:0]   drive_sum;
    logic signed [ACC_W-1:0]  drive_prod;
    logic signed [FX_W-1:0]   drive_next;

    ////////////////////
    // free running noise
    ////////////////////
    always_ff @(posedge i_neuron_clk or posedge i_reset_sim) begin
        if (i_reset_sim) begin
            lfsr <= LFSR_SEED;
        end else if (lfsr[0]) begin
            lfsr <= (lfsr >> 1) ^ LFSR_TAPS;
        end else begin
            lfsr <= lfsr >> 1;
        end
    end

    ////////////////////
    // rate x coef + noise, then gain
    ////////////////////
    // product at 2^32, back to 2^16 with sign kept
    assign rate_prod = i_rate * i_coef;
    assign rate_scaled = {rate_prod[ACC_W-1], rate_prod[FX_FRAC+FX_W-2:FX_FRAC]};

    // small positive jitter, 0 to 31 lsb
    assign noise_term = i_noise_en ? {{(FX_W-NOISE_W){1'b0}}, lfsr[NOISE_W-1:0]} : '0;
    assign drive_sum = rate_scaled + noise_term;

    // gain is an integer multiplier, sign plus low bits kept
    assign drive_prod = drive_sum * i_gain;
    assign drive_next = {drive_prod[ACC_W-1], drive_prod[FX_W-2:0]};

    // one load per neuron slot
    always_ff @(posedge i_neuron_clk or posedge i_reset_sim) begin
        if (i_reset_sim) begin
            o_current <= '0;
        end else if (phase.read_strobe) begin
            o_current <= drive_next;
        end
    end

endmodule

// File: hdl/izh_neuron_core.sv
`timescale 1ns/1ps

module izh_neuron_core import neuron_pool_pkg::*; (
    input  logic                   i_neuron_clk,
    input  logic                   i_reset_sim,
    input  logic signed [FX_W-1:0] i_current,
    pool_phase_if.user             phase,
    output logic                   o_event_valid,
    output spike_event_t           o_event
);

    // per neuron state
    logic signed [FX_W-1:0] v_mem [NUM_NEURON];
    logic signed [FX_W-1:0] u_mem [NUM_NEURON];

    // init sweep after reset
    logic                   sweep_busy;
    logic [IDX_W-1:0]       sweep_index;

    logic [IDX_W-1:0]       slot_index;
    logic signed [FX_W-1:0] v_cur;
    logic signed [FX_W-1:0] u_cur;
    logic signed [FX_W-1:0] v_upd;
    logic signed [FX_W-1:0] u_upd;
    logic                   spike_pend;

    logic signed [ACC_W-1:0] v_ext;
    logic signed [ACC_W-1:0] u_ext;
    logic signed [ACC_W-1:0] vv;
    logic signed [ACC_W-1:0] dv_sum;
    logic signed [ACC_W-1:0] v_wide;
    logic signed [ACC_W-1:0] u_wide;
    logic                    fire;

    // clip a wide result back to the state width
    function automatic logic signed [FX_W-1:0] sat_fx(input logic signed [ACC_W-1:0] x);
        logic signed [FX_W-1:0] r;
        if (x > FX_MAX) begin
            r = FX_MAX;
        end else if (x < FX_MIN) begin
            r = FX_MIN;
        end else begin
            r = x[FX_W-1:0];
        end
        return r;
    endfunction

    ////////////////////
    // reset sweep
    ////////////////////
    // one neuron per cycle, yields to write phase
    always_ff @(posedge i_neuron_clk or posedge i_reset_sim) begin
        if (i_reset_sim) begin
            sweep_busy <= 1'b1;
            sweep_index <= '0;
        end else if (sweep_busy && !phase.write_strobe) begin
            if (sweep_index == IDX_W'(NUM_NEURON - 1)) begin
                sweep_busy <= 1'b0;
            end
            sweep_index <= sweep_index + 1'b1;
        end
    end

    ////////////////////
    // slot control
    ////////////////////
    always_ff @(posedge i_neuron_clk or posedge i_reset_sim) begin
        if (i_reset_sim) begin
            slot_index <= '0;
            spike_pend <= 1'b0;
        end else begin
            // latch slot when the counter moves on
            if (phase.advance) begin
                slot_index <= phase.neuron_index;
            end
            if (phase.compute_strobe) begin
                spike_pend <= fire;
            end
        end
    end

    // state memory, update write wins over the sweep
    always_ff @(posedge i_neuron_clk) begin
        if (phase.write_strobe) begin
            v_mem[slot_index] <= v_upd;
            u_mem[slot_index] <= u_upd;
        end else if (sweep_busy) begin
            v_mem[sweep_index] <= C_RESET;
            u_mem[sweep_index] <= '0;
        end
    end

    // read and compute registers
    always_ff @(posedge i_neuron_clk) begin
        if (phase.read_strobe) begin
            v_cur <= v_mem[slot_index];
            u_cur <= u_mem[slot_index];
        end
        if (phase.compute_strobe) begin
            // on spike v snaps back, u steps up by d
            v_upd <= fire ? C_RESET : sat_fx(v_wide);
            u_upd <= fire ? sat_fx(u_wide + ACC_W'(D_STEP)) : sat_fx(u_wide);
        end
    end

    ////////////////////
    // izhikevich update
    ////////////////////
    assign v_ext = ACC_W'(v_cur);
    assign u_ext = ACC_W'(u_cur);
    assign vv = v_cur * v_cur;

    // 4 v^2 + 5 v + 1.40 - u + I
    assign dv_sum = (vv >>> VV_SHIFT) + (v_ext <<< 2) + v_ext + ACC_W'(K_BIAS) - u_ext
                  + ACC_W'(i_current);
    assign v_wide = v_ext + (dv_sum >>> TAU_SHIFT);

    // a (b v - u)
    assign u_wide = u_ext + (((v_ext >>> B_SHIFT) - u_ext) >>> A_SHIFT);
    assign fire = (v_wide >= ACC_W'(V_PEAK));

    ////////////////////
    // spike event
    ////////////////////
    assign o_event_valid = phase.write_strobe && spike_pend;
    assign o_event.index = slot_index;
    assign o_event.valid = o_event_valid;

endmodule

// File: hdl/spike_credit_tx.sv
`timescale 1ns/1ps

module spike_credit_tx import neuron_pool_pkg::*; (
    input  logic                i_neuron_clk,
    input  logic                i_reset_sim,
    input  logic                i_event_valid,
    input  spike_event_t        i_event,
    input  logic                i_credit_return,
    output logic                o_spk_valid,
    output logic [SPK_ID_W-1:0] o_spk_id,
    output logic                o_overflow
);

    // queue of neuron indices
    logic [IDX_W-1:0]    q_mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0]   wr_ptr;
    logic [QPTR_W-1:0]   rd_ptr;
    logic [QPTR_W:0]     q_count;
    logic [CREDIT_W-1:0] credits;

    logic push;
    logic push_ok;
    logic pop;

    assign push = i_event_valid && i_event.valid;
    // no backpressure upstream, a full queue drops
    assign push_ok = push && (q_count != (QPTR_W+1)'(QUEUE_DEPTH));
    // send only while a credit is held
    assign pop = (q_count != '0) && (credits != '0);

    always_ff @(posedge i_neuron_clk) begin
        if (push_ok) begin
            q_mem[wr_ptr] <= i_event.index;
        end
        if (pop) begin
            // {0, index, motoneuron flag, zeros}
            o_spk_id <= {1'b0, SPK_IDX_W'(q_mem[rd_ptr]), 1'b1, {SPK_LOW_W{1'b0}}};
        end
    end

    ////////////////////
    // pointers and credits
    ////////////////////
    always_ff @(posedge i_neuron_clk or posedge i_reset_sim) begin
        if (i_reset_sim) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
            credits <= CREDIT_W'(CREDIT_INIT);
            o_spk_valid <= 1'b0;
            o_overflow <= 1'b0;
        end else begin
            o_spk_valid <= pop;
            // sticky until reset
            if (push && !push_ok) begin
                o_overflow <= 1'b1;
            end
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop})
                2'b10: q_count <= q_count + 1'b1;
                2'b01: q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            // a return beyond the initial count is ignored
            if (pop && !i_credit_return) begin
                credits <= credits - 1'b1;
            end else if (!pop && i_credit_return
                         && (credits != CREDIT_W'(CREDIT_INIT))) begin
                credits <= credits + 1'b1;
            end
        end
    end

endmodule

// File: hdl/neuron_pool_top.sv
`timescale 1ns/1ps

module neuron_pool_top import neuron_pool_pkg::*; (
    input  logic                   i_neuron_clk,
    input  logic                   i_reset_sim,
    input  logic signed [FX_W-1:0] i_rate,
    input  logic signed [FX_W-1:0] i_coef,
    input  logic signed [FX_W-1:0] i_gain,
    input  logic                   i_noise_en,
    input  logic                   i_credit_return,
    output logic                   o_spk_valid,
    output logic [SPK_ID_W-1:0]    o_spk_id,
    output logic signed [FX_W-1:0] o_current,
    output logic                   o_overflow
);

    // core to transmitter
    logic         event_valid;
    spike_event_t spike_event;

    ////////////////////
    // phase fabric
    ////////////////////
    pool_phase_if phase_if ();

    pool_sequencer pool_sequencer_i (
        .i_neuron_clk (i_neuron_clk),
        .i_reset_sim  (i_reset_sim),
        .phase        (phase_if)
    );

    ////////////////////
    // drive current, shared by all neurons
    ////////////////////
    input_current input_current_i (
        .i_neuron_clk (i_neuron_clk),
        .i_reset_sim  (i_reset_sim),
        .i_rate       (i_rate),
        .i_coef       (i_coef),
        .i_gain       (i_gain),
        .i_noise_en   (i_noise_en),
        .phase        (phase_if),
        .o_current    (o_current)
    );

    izh_neuron_core izh_neuron_core_i (
        .i_neuron_clk  (i_neuron_clk),
        .i_reset_sim   (i_reset_sim),
        .i_current     (o_current),
        .phase         (phase_if),
        .o_event_valid (event_valid),
        .o_event       (spike_event)
    );

    ////////////////////
    // spike output
    ////////////////////
    spike_credit_tx spike_credit_tx_i (
        .i_neuron_clk    (i_neuron_clk),
        .i_reset_sim     (i_reset_sim),
        .i_event_valid   (event_valid),
        .i_event         (spike_event),
        .i_credit_return (i_credit_return),
        .o_spk_valid     (o_spk_valid),
        .o_spk_id        (o_spk_id),
        .o_overflow      (o_overflow)
    );

endmodule

// File: sim/tb_neuron_pool.sv
`timescale 1ns/1ps

module tb_neuron_pool import neuron_pool_pkg::*; ();

    localparam int unsigned SEED = 32'h6bb7_0640;
    localparam int QUIET_ROUNDS = 20;
    localparam int FIRE_ROUNDS = 10;
    localparam int HOLD_ROUNDS = 3;
    localparam int RESUME_ROUNDS = 2;
    localparam int OVF_ROUNDS = 6;
    localparam int STICK_ROUNDS = 3;
    // reset and current checks plus one round per reset
    localparam int BUDGET_ROUNDS = 7 + QUIET_ROUNDS + 2 * FIRE_ROUNDS + HOLD_ROUNDS
                                 + RESUME_ROUNDS + OVF_ROUNDS + STICK_ROUNDS;
    localparam int TIMEOUT_CYCLES = BUDGET_ROUNDS * POOL_CYCLES * 6 / 5;
    // 1.0 x 0.75 x 2 gives about 1.5 drive
    localparam logic signed [FX_W-1:0] STRONG_RATE = 18'sh1_0000;
    localparam logic signed [FX_W-1:0] STRONG_COEF = 18'sh0_C000;
    localparam logic signed [FX_W-1:0] STRONG_GAIN = 18'sh0_0002;

    logic                   neuron_clk = 1'b0;
    logic                   reset_sim;
    logic signed [FX_W-1:0] rate;
    logic signed [FX_W-1:0] coef;
    logic signed [FX_W-1:0] gain;
    logic                   noise_en;
    logic                   credit_return = 1'b0;
    logic                   spk_valid;
    logic [SPK_ID_W-1:0]    spk_id;
    logic signed [FX_W-1:0] current;
    logic                   overflow;

    // consumer model state
    int                    error_count = 0;
    int                    cycle_count = 0;
    int                    total_sent = 0;
    int                    total_returned = 0;
    int                    expect_index = 0;
    logic [NUM_NEURON-1:0] seen_mask = '0;
    bit                    hold_credits = 1'b0;
    bit                    check_order = 1'b0;
    bit                    slot_busy [CREDIT_INIT];
    int                    slot_timer [CREDIT_INIT];

    always #50 neuron_clk = ~neuron_clk;

    always @(posedge neuron_clk) cycle_count <= cycle_count + 1;

    neuron_pool_top neuron_pool_top_i (
        .i_neuron_clk    (neuron_clk),
        .i_reset_sim     (reset_sim),
        .i_rate          (rate),
        .i_coef          (coef),
        .i_gain          (gain),
        .i_noise_en      (noise_en),
        .i_credit_return (credit_return),
        .o_spk_valid     (spk_valid),
        .o_spk_id        (spk_id),
        .o_current       (current),
        .o_overflow      (overflow)
    );

    ////////////////////
    // reference rules
    ////////////////////
    // rate x coef back at 2^16 plus noise
    // then times the integer gain with sign and low 17 bits kept
    function automatic logic signed [FX_W-1:0] expected_current(
        input logic signed [FX_W-1:0] r, c, g, input int noise);
        longint                 prod;
        longint                 drive;
        logic signed [FX_W-1:0] scaled;
        prod = longint'(r) * longint'(c);
        scaled = {prod[63], prod[32:16]};
        scaled = scaled + FX_W'(noise);
        drive = longint'(scaled) * longint'(g);
        return {drive[63], drive[16:0]};
    endfunction

    // zero msb, index field, motoneuron flag, zero low bits
    function automatic logic [SPK_ID_W-1:0] expected_spike_id(input int index);
        logic [SPK_ID_W-1:0] id;
        id = '0;
        id[SPK_ID_W-2 -: SPK_IDX_W] = SPK_IDX_W'(index);
        id[SPK_LOW_W] = 1'b1;
        return id;
    endfunction

    function automatic int free_slots();
        int free;
        free = 0;
        for (int k = 0; k < CREDIT_INIT; k++) begin
            if (!slot_busy[k]) begin
                free++;
            end
        end
        return free;
    endfunction

    task automatic check_equal(input int got, input int exp, input string what);
        assert (got == exp) else begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////
    task automatic set_drive(input logic signed [FX_W-1:0] r, c, g, input logic n);
        @(negedge neuron_clk);
        rate = r;
        coef = c;
        gain = g;
        noise_en = n;
    endtask

    // held for three cycles and released on a falling edge
    task automatic apply_reset();
        @(negedge neuron_clk);
        reset_sim = 1'b1;
        repeat (3) @(posedge neuron_clk);
        @(negedge neuron_clk);
        reset_sim = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge neuron_clk);
    endtask

    task automatic wait_for_sent(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (total_sent < target && n < limit) begin
            @(posedge neuron_clk);
            n++;
        end
        assert (total_sent >= target) else begin
            error_count++;
            $display("at %0t: %s did not arrive within %0d cycles", $time, what, limit);
        end
    endtask

    ////////////////////
    // consumer model
    ////////////////////
    // one slot per credit freed after 0 to 7 cycles unless held
    initial begin : consumer_model
        int          free_before;
        bit          returned;
        bit          claimed;
        logic [SPK_IDX_W-1:0] id_index;
        void'($urandom(SEED));
        forever begin
            @(negedge neuron_clk);
            credit_return = 1'b0;
            if (reset_sim) begin
                total_sent = 0;
                total_returned = 0;
                expect_index = 0;
                seen_mask = '0;
                for (int k = 0; k < CREDIT_INIT; k++) begin
                    slot_busy[k] = 1'b0;
                end
            end else begin
                free_before = free_slots();
                returned = 1'b0;
                // at most one return pulse per cycle
                for (int k = 0; k < CREDIT_INIT; k++) begin
                    if (slot_busy[k] && !hold_credits) begin
                        if (slot_timer[k] > 0) begin
                            slot_timer[k]--;
                        end else if (!returned) begin
                            slot_busy[k] = 1'b0;
                            returned = 1'b1;
                            credit_return = 1'b1;
                            total_returned++;
                        end
                    end
                end
                if (spk_valid) begin
                    id_index = spk_id[SPK_ID_W-2 -: SPK_IDX_W];
                    assert (free_before > 0 && total_sent < CREDIT_INIT + total_returned)
                    else begin
                        error_count++;
                        $display("at %0t: spike sent while the consumer had no credit free",
                                 $time);
                    end
                    total_sent++;
                    check_equal(spk_id, expected_spike_id(id_index), "spike id");
                    check_equal(int'(id_index < NUM_NEURON), 1, "spike index in pool");
                    if (id_index < NUM_NEURON) begin
                        seen_mask[id_index] = 1'b1;
                    end
                    // whole pool fires together so ids come in slot order
                    if (check_order) begin
                        check_equal(id_index, expect_index, "spike index");
                    end
                    expect_index = (id_index + 1) % NUM_NEURON;
                    claimed = 1'b0;
                    for (int k = 0; k < CREDIT_INIT; k++) begin
                        if (!slot_busy[k] && !claimed) begin
                            slot_busy[k] = 1'b1;
                            slot_timer[k] = $urandom % 8;
                            claimed = 1'b1;
                        end
                    end
                end
            end
        end
    end

    ////////////////////
    // directed tests
    ////////////////////
    task automatic reset_values_hold();
        @(negedge neuron_clk);
        reset_sim = 1'b1;
        for (int k = 0; k < 4; k++) begin
            @(negedge neuron_clk);
            check_equal(spk_valid, 0, "o_spk_valid at reset");
            check_equal(overflow, 0, "o_overflow at reset");
            check_equal(current, 0, "o_current at reset");
            // released after the third cycle so the last pass sees the first cycle out
            if (k == 2) begin
                reset_sim = 1'b0;
            end
        end
    endtask

    task automatic check_current(input logic signed [FX_W-1:0] r, c, g);
        set_drive(r, c, g, 1'b0);
        // any four edges hold one read strobe
        repeat (4) @(posedge neuron_clk);
        @(negedge neuron_clk);
        check_equal(current, expected_current(r, c, g, 0), "o_current");
    endtask

    task automatic current_matches_rule();
        logic signed [FX_W-1:0] lo;
        logic signed [FX_W-1:0] hi;
        bit                     noise_seen;
        check_current(18'sh1_0000, 18'sh0_8000, 18'sh0_0001);
        check_current(18'sh0_C000, 18'sh3_0000, 18'sh0_0003);
        check_current(18'sh1_8000, 18'sh0_4000, 18'sh3_FFFE);
        check_current(18'sh3_8000, 18'sh3_8000, 18'sh0_0004);
        // noise adds 0 to 31 lsb ahead of the gain
        set_drive(18'sh0_8000, 18'sh0_8000, 18'sh0_0002, 1'b1);
        lo = expected_current(18'sh0_8000, 18'sh0_8000, 18'sh0_0002, 0);
        hi = expected_current(18'sh0_8000, 18'sh0_8000, 18'sh0_0002, 31);
        noise_seen = 1'b0;
        repeat (8) begin
            repeat (4) @(posedge neuron_clk);
            @(negedge neuron_clk);
            check_equal(int'(current >= lo && current <= hi), 1, "o_current noise window");
            // gain of two puts every noise step on an even offset
            check_equal(int'((current - lo) % 2), 0, "o_current noise step");
            if (current != lo) begin
                noise_seen = 1'b1;
            end
        end
        check_equal(noise_seen, 1, "noise reaching o_current");
    endtask

    task automatic quiet_pool_stays_silent();
        set_drive(18'sh1_0000, 18'sh0_8000, 18'sh0_0000, 1'b0);
        apply_reset();
        wait_cycles(QUIET_ROUNDS * POOL_CYCLES);
        check_equal(total_sent, 0, "spikes at zero current");
    endtask

    task automatic spikes_cover_all_neurons();
        check_order = 1'b1;
        set_drive(STRONG_RATE, STRONG_COEF, STRONG_GAIN, 1'b0);
        apply_reset();
        wait_cycles(FIRE_ROUNDS * POOL_CYCLES);
        check_equal(seen_mask, {NUM_NEURON{1'b1}}, "neurons seen");
        check_order = 1'b0;
    endtask

    task automatic credits_limit_transfers();
        hold_credits = 1'b1;
        set_drive(STRONG_RATE, STRONG_COEF, STRONG_GAIN, 1'b0);
        apply_reset();
        wait_for_sent(CREDIT_INIT, FIRE_ROUNDS * POOL_CYCLES, "initial credit spikes");
        wait_cycles(HOLD_ROUNDS * POOL_CYCLES);
        check_equal(total_sent, CREDIT_INIT, "spikes with credits withheld");
        hold_credits = 1'b0;
        wait_for_sent(CREDIT_INIT + 1, RESUME_ROUNDS * POOL_CYCLES, "spikes after credit return");
        check_equal(int'(total_returned > 0), 1, "credits returned");
    endtask

    task automatic overflow_flag_sticks();
        int n;
        bit stuck;
        hold_credits = 1'b1;
        set_drive(STRONG_RATE, STRONG_COEF, STRONG_GAIN, 1'b0);
        apply_reset();
        check_equal(overflow, 0, "o_overflow after reset");
        n = 0;
        while (!overflow && n < OVF_ROUNDS * POOL_CYCLES) begin
            @(negedge neuron_clk);
            n++;
        end
        check_equal(overflow, 1, "o_overflow with credits withheld");
        @(posedge neuron_clk);
        hold_credits = 1'b0;
        stuck = 1'b1;
        repeat (STICK_ROUNDS * POOL_CYCLES) begin
            @(negedge neuron_clk);
            stuck &= overflow;
        end
        check_equal(stuck, 1, "o_overflow held");
        apply_reset();
        check_equal(overflow, 0, "o_overflow cleared by reset");
    endtask

    task automatic finish_run();
        $display("errors: %0d, spikes: %0d, credits returned: %0d, cycles: %0d",
                 error_count, total_sent, total_returned, cycle_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        reset_sim = 1'b0;
        rate = '0;
        coef = '0;
        gain = '0;
        noise_en = 1'b0;
        reset_values_hold();
        current_matches_rule();
        quiet_pool_stays_silent();
        spikes_cover_all_neurons();
        credits_limit_transfers();
        overflow_flag_sticks();
        finish_run();
    end

    // run limit from the summed test rounds
    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        error_count++;
        $display("timeout: tests still running after %0d cycles", cycle_count);
        finish_run();
    end

endmodule

// File: compile.f
hdl/neuron_pool_pkg.sv
hdl/pool_phase_if.sv
hdl/pool_sequencer.sv
hdl/input_current.sv
hdl/izh_neuron_core.sv
hdl/spike_credit_tx.sv
hdl/neuron_pool_top.sv
sim/tb_neuron_pool.sv
